//--- compile.f
+incdir+logic
logic/command_pkg.sv
logic/economy_pkg.sv
logic/click_encoder.sv
logic/command_fifo.sv
logic/purse_controller.sv
logic/game_economy.sv
tests/tb_game_economy.sv

//--- logic/click_encoder.sv
`include "economy_params.svh"

module click_encoder (
    input  logic                       clk_25MHz,
    input  logic                       rst,
    input  logic [`ECON_UNIT_TYPES-1:0] buy_click,
    input  logic                       upgrade_click,
    output logic                       wr_cyc,
    output logic                       wr_stb,
    output logic                       wr_we,
    output command_pkg::cmd_word_t     wr_dat,
    input  logic                       wr_ack
);
    import command_pkg::*;

    logic                        upgrade_req;
    logic [`ECON_UNIT_TYPES-1:0] buy_req;
    logic                        wr_open;
    logic                        sel_upgrade;   // request bit owned by the open write
    logic [`ECON_UNIT_TYPES-1:0] sel_buy;
    logic [`ECON_UNIT_TYPES-1:0] lowest_buy;
    cmd_word_t                   next_cmd;

    assign wr_cyc = wr_open;
    assign wr_stb = wr_open;
    assign wr_we  = wr_open;    // write-only master

    // pick upgrade first, then lowest buy
    always_comb begin
        lowest_buy    = buy_req & (~buy_req + 1'b1);
        next_cmd.op   = upgrade_req ? CMD_UPGRADE_PURSE : CMD_BUY_UNIT;
        next_cmd.unit = killer_bird;
        for (int i = `ECON_UNIT_TYPES - 1; i >= 0; i--) begin
            if (buy_req[i])
                next_cmd.unit = unit_type_e'(i);
        end
    end

    // --------------------
    // sticky requests and write cycle
    always_ff @(posedge clk_25MHz or posedge rst) begin
        if (rst) begin
            upgrade_req <= 1'b0;
            buy_req     <= '0;
            wr_open     <= 1'b0;
        end else begin
            upgrade_req <= upgrade_click | (upgrade_req & ~(wr_ack & sel_upgrade));
            buy_req     <= buy_click | (buy_req & ~(wr_ack ? sel_buy : '0));
            if (wr_open) begin
                if (wr_ack)
                    wr_open <= 1'b0;    // drop stb after ack
            end else if (upgrade_req || buy_req != '0) begin
                wr_open <= 1'b1;
            end
        end
    end

    // data held steady while the write is open
    always_ff @(posedge clk_25MHz) begin
        if (!wr_open) begin
            wr_dat      <= next_cmd;
            sel_upgrade <= upgrade_req;
            sel_buy     <= upgrade_req ? '0 : lowest_buy;
        end
    end

endmodule

//--- logic/command_fifo.sv
`include "economy_params.svh"

module command_fifo (
    input  logic                   clk_25MHz,
    input  logic                   rst,
    input  logic                   wr_cyc,
    input  logic                   wr_stb,
    input  logic                   wr_we,
    input  command_pkg::cmd_word_t wr_dat,
    output logic                   wr_ack,
    input  logic                   rd_cyc,
    input  logic                   rd_stb,
    output command_pkg::cmd_word_t rd_dat,
    output logic                   rd_ack
);
    import command_pkg::*;

    cmd_word_t                mem [`ECON_FIFO_DEPTH];
    logic [`ECON_FIFO_AW-1:0] wr_ptr;
    logic [`ECON_FIFO_AW-1:0] rd_ptr;
    logic [`ECON_FIFO_AW:0]   count;
    logic                     full;
    logic                     push;
    logic                     pop;
    logic                     rd_req;

    assign full   = (count == `ECON_FIFO_DEPTH);
    assign push   = wr_cyc && wr_stb && wr_we && !wr_ack && !full;  // held off while full
    assign rd_req = rd_cyc && rd_stb && !rd_ack;
    assign pop    = rd_req && count != '0;

    // --------------------
    // pointers and acks
    always_ff @(posedge clk_25MHz or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            wr_ack <= 1'b0;
            rd_ack <= 1'b0;
        end else begin
            wr_ack <= push;
            rd_ack <= rd_req;   // reads never stall
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + push - pop;
        end
    end

    // storage and read data
    always_ff @(posedge clk_25MHz) begin
        if (push)
            mem[wr_ptr] <= wr_dat;
        if (pop) begin
            rd_dat <= mem[rd_ptr];
        end else if (rd_req) begin
            rd_dat.op   <= CMD_NONE;    // empty
            rd_dat.unit <= killer_bird;
        end
    end

endmodule

//--- logic/command_pkg.sv
`include "economy_params.svh"

package command_pkg;

    // opcodes carried on both wishbone links
    typedef enum logic [1:0] {
        CMD_NONE          = 2'd0,   // empty read
        CMD_BUY_UNIT      = 2'd1,
        CMD_UPGRADE_PURSE = 2'd2
    } cmd_op_e;

    // one per screen button from button 0 up
    typedef enum logic [`ECON_UNIT_W-1:0] {
        killer_bird = 3'd0,
        white_bear  = 3'd1,
        metal_duck  = 3'd2,
        black_bear  = 3'd3,
        gold_eagle  = 3'd4,
        iron_ram    = 3'd5,
        storm_wolf  = 3'd6,
        fire_dragon = 3'd7
    } unit_type_e;

    typedef struct packed {
        cmd_op_e    op;
        unit_type_e unit;     // ignored for upgrades
    } cmd_word_t;

endpackage

//--- logic/economy_params.svh
`ifndef ECONOMY_PARAMS_SVH
`define ECONOMY_PARAMS_SVH

// money and purse
`define ECON_MONEY_W    15      // holds the top cap of 4000
`define ECON_PURSE_MAX  7

// --------------------
// unit buttons
`define ECON_UNIT_TYPES 8
`define ECON_UNIT_W     3

// --------------------
// command buffer
`define ECON_FIFO_DEPTH 4
`define ECON_FIFO_AW    2

`endif

//--- logic/economy_pkg.sv
`include "economy_params.svh"

package economy_pkg;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_FETCH  = 2'd1,
        ST_APPLY  = 2'd2,
        ST_INCOME = 2'd3
    } econ_state_e;

    typedef logic [`ECON_MONEY_W-1:0]                 money_t;
    typedef logic [$clog2(`ECON_PURSE_MAX + 1)-1:0]   purse_level_t;

    // --------------------
    // price tables
    function automatic money_t unit_cost(command_pkg::unit_type_e t);
        case (t)
            command_pkg::killer_bird: return money_t'(50);
            command_pkg::white_bear:  return money_t'(100);
            command_pkg::metal_duck:  return money_t'(150);
            command_pkg::black_bear:  return money_t'(200);
            command_pkg::gold_eagle:  return money_t'(300);
            command_pkg::iron_ram:    return money_t'(400);
            command_pkg::storm_wolf:  return money_t'(500);
            default:                  return money_t'(750);
        endcase
    endfunction

    function automatic money_t purse_upgrade_cost(purse_level_t lvl);
        return money_t'(40 * (lvl + 1));
    endfunction

    function automatic money_t purse_cap(purse_level_t lvl);
        return money_t'(500 * (lvl + 1));
    endfunction

    // income per game tick
    function automatic money_t purse_income(purse_level_t lvl);
        case (lvl)
            3'd0:       return money_t'(1);
            3'd1, 3'd2: return money_t'(2);
            3'd3:       return money_t'(3);
            3'd4:       return money_t'(4);
            default:    return money_t'(5);
        endcase
    endfunction

endpackage

//--- logic/game_economy.sv
`include "economy_params.svh"

module game_economy (
    input  logic                       clk_25MHz,
    input  logic                       rst,
    input  logic                       game_init,
    input  logic                       tick,
    input  logic [`ECON_UNIT_TYPES-1:0] buy_click,
    input  logic                       upgrade_click,
    output economy_pkg::money_t        money,
    output economy_pkg::purse_level_t  purse_level,
    output logic                       able_to_upgrade,
    output logic                       spawn_valid,
    output command_pkg::unit_type_e    spawn_type
);
    import command_pkg::*;

    // write link
    logic      wr_cyc;
    logic      wr_stb;
    logic      wr_we;
    cmd_word_t wr_dat;
    logic      wr_ack;

    // read link
    logic      rd_cyc;
    logic      rd_stb;
    cmd_word_t rd_dat;
    logic      rd_ack;

    click_encoder i_click_encoder (
        .clk_25MHz     (clk_25MHz),
        .rst           (rst),
        .buy_click     (buy_click),
        .upgrade_click (upgrade_click),
        .wr_cyc        (wr_cyc),
        .wr_stb        (wr_stb),
        .wr_we         (wr_we),
        .wr_dat        (wr_dat),
        .wr_ack        (wr_ack)
    );

    command_fifo i_command_fifo (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .wr_cyc    (wr_cyc),
        .wr_stb    (wr_stb),
        .wr_we     (wr_we),
        .wr_dat    (wr_dat),
        .wr_ack    (wr_ack),
        .rd_cyc    (rd_cyc),
        .rd_stb    (rd_stb),
        .rd_dat    (rd_dat),
        .rd_ack    (rd_ack)
    );

    purse_controller i_purse_controller (
        .clk_25MHz       (clk_25MHz),
        .rst             (rst),
        .game_init       (game_init),
        .tick            (tick),
        .rd_cyc          (rd_cyc),
        .rd_stb          (rd_stb),
        .rd_dat          (rd_dat),
        .rd_ack          (rd_ack),
        .money           (money),
        .purse_level     (purse_level),
        .able_to_upgrade (able_to_upgrade),
        .spawn_valid     (spawn_valid),
        .spawn_type      (spawn_type)
    );

endmodule

//--- logic/purse_controller.sv
`include "economy_params.svh"

module purse_controller (
    input  logic                       clk_25MHz,
    input  logic                       rst,
    input  logic                       game_init,
    input  logic                       tick,
    output logic                       rd_cyc,
    output logic                       rd_stb,
    input  command_pkg::cmd_word_t     rd_dat,
    input  logic                       rd_ack,
    output economy_pkg::money_t        money,
    output economy_pkg::purse_level_t  purse_level,
    output logic                       able_to_upgrade,
    output logic                       spawn_valid,
    output command_pkg::unit_type_e    spawn_type
);
    import command_pkg::*;
    import economy_pkg::*;

    econ_state_e             state;
    econ_state_e             next_state;
    money_t                  next_money;
    purse_level_t            next_level;
    logic                    tick_pend;
    logic                    next_tick_pend;
    logic                    spawn_now;
    cmd_word_t               cmd_q;
    money_t                  unit_price;
    money_t                  upgrade_price;
    money_t                  cap;
    logic [`ECON_MONEY_W:0]  income_sum;    // one spare bit
    logic                    at_top;

    assign unit_price    = unit_cost(cmd_q.unit);
    assign upgrade_price = purse_upgrade_cost(purse_level);
    assign cap           = purse_cap(purse_level);
    assign income_sum    = money + purse_income(purse_level);
    assign at_top        = (purse_level == purse_level_t'(`ECON_PURSE_MAX));

    assign able_to_upgrade = (money >= upgrade_price) && !at_top;

    // read strobe only while fetching
    assign rd_cyc = (state == ST_FETCH);
    assign rd_stb = (state == ST_FETCH);

    // --------------------
    // command loop
    always_comb begin
        next_state     = state;
        next_money     = money;
        next_level     = purse_level;
        next_tick_pend = tick_pend | tick;
        spawn_now      = 1'b0;

        case (state)
            ST_IDLE: begin
                next_state = tick_pend ? ST_INCOME : ST_FETCH;
            end
            ST_FETCH: begin
                if (rd_ack)
                    next_state = ST_APPLY;
            end
            ST_APPLY: begin
                next_state = ST_IDLE;
                case (cmd_q.op)
                    CMD_BUY_UNIT: begin
                        if (unit_price <= money) begin
                            next_money = money - unit_price;
                            spawn_now  = 1'b1;
                        end     // else dropped for lack of money
                    end
                    CMD_UPGRADE_PURSE: begin
                        if (!at_top && upgrade_price <= money) begin
                            next_money = money - upgrade_price;
                            next_level = purse_level + 1'b1;
                        end
                    end
                    default: ;  // empty fetch
                endcase
            end
            ST_INCOME: begin
                next_state     = ST_IDLE;
                next_tick_pend = tick;      // a fresh tick is kept
                if (income_sum > {1'b0, cap})
                    next_money = cap;
                else
                    next_money = income_sum[`ECON_MONEY_W-1:0];
            end
            default: next_state = ST_IDLE;
        endcase

        // new game
        if (game_init) begin
            next_money     = '0;
            next_level     = '0;
            next_tick_pend = 1'b0;
        end
    end

    // --------------------
    always_ff @(posedge clk_25MHz or posedge rst) begin
        if (rst) begin
            state       <= ST_IDLE;
            money       <= '0;
            purse_level <= '0;
            tick_pend   <= 1'b0;
            spawn_valid <= 1'b0;
        end else begin
            state       <= next_state;
            money       <= next_money;
            purse_level <= next_level;
            tick_pend   <= next_tick_pend;
            spawn_valid <= spawn_now;
        end
    end

    always_ff @(posedge clk_25MHz) begin
        if (state == ST_FETCH && rd_ack)
            cmd_q <= rd_dat;
        if (spawn_now)
            spawn_type <= cmd_q.unit;
    end

endmodule

//--- tests/tb_game_economy.sv
`include "economy_params.svh"

module tb_game_economy;
    timeunit 1ns;
    timeprecision 100ps;

    import command_pkg::*;
    import economy_pkg::*;

    localparam int CYCLE_LIMIT = 20000;     // tests need about 6000
    localparam int SPAWN_WAIT  = 40;

    logic                        clk_25MHz;
    logic                        rst;
    logic                        game_init;
    logic                        tick;
    logic [`ECON_UNIT_TYPES-1:0] buy_click;
    logic                        upgrade_click;
    money_t                      money;
    purse_level_t                purse_level;
    logic                        able_to_upgrade;
    logic                        spawn_valid;
    unit_type_e                  spawn_type;

    int     exp_money;      // reference purse
    int     exp_level;
    int     cycle_count = 0;
    integer seed = 32'hf883;

    game_economy i_game_economy (
        .clk_25MHz       (clk_25MHz),
        .rst             (rst),
        .game_init       (game_init),
        .tick            (tick),
        .buy_click       (buy_click),
        .upgrade_click   (upgrade_click),
        .money           (money),
        .purse_level     (purse_level),
        .able_to_upgrade (able_to_upgrade),
        .spawn_valid     (spawn_valid),
        .spawn_type      (spawn_type)
    );

    always #20 clk_25MHz = ~clk_25MHz;

    always @(posedge clk_25MHz) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT)
            fail_run("error: run timed out before the tests finished");
    end

    // --------------------
    // economy rules
    function automatic int cost_of_unit(input int t);
        case (t)
            0: return 50;
            1: return 100;
            2: return 150;
            3: return 200;
            4: return 300;
            5: return 400;
            6: return 500;
            default: return 750;
        endcase
    endfunction

    function automatic int upgrade_price_at(input int lvl);
        return 40 * (lvl + 1);
    endfunction

    function automatic int money_cap_at(input int lvl);
        return 500 * (lvl + 1);
    endfunction

    function automatic int income_at(input int lvl);
        case (lvl)
            0: return 1;
            1, 2: return 2;
            3: return 3;
            4: return 4;
            default: return 5;
        endcase
    endfunction

    // --------------------
    // helpers
    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
            fail_run($sformatf("error: %s expected %0d actual %0d",
                               test_name, expected, actual));
    endtask

    task automatic next_cycle();
        @(posedge clk_25MHz);
        #2;     // drive just after the edge
    endtask

    task automatic tick_and_check(input string test_name);
        tick = 1'b1;
        next_cycle();
        tick = 1'b0;
        repeat (9) next_cycle();
        exp_money = exp_money + income_at(exp_level);
        if (exp_money > money_cap_at(exp_level))
            exp_money = money_cap_at(exp_level);
        check_value(test_name, exp_money, money);
    endtask

    task automatic click_buttons(input logic [`ECON_UNIT_TYPES-1:0] mask, input logic upg);
        buy_click     = mask;
        upgrade_click = upg;
        next_cycle();
        buy_click     = '0;
        upgrade_click = 1'b0;
    endtask

    task automatic wait_for_spawn(input string test_name, input int unit);
        int n;
        for (n = 0; n < SPAWN_WAIT && !spawn_valid; n++)
            next_cycle();
        if (!spawn_valid)
            fail_run($sformatf("error: %s saw no spawn of unit %0d in time", test_name, unit));
        exp_money = exp_money - cost_of_unit(unit);
        check_value(test_name, unit, spawn_type);
        check_value(test_name, exp_money, money);
        next_cycle();
    endtask

    task automatic expect_no_spawn(input string test_name);
        repeat (SPAWN_WAIT) begin
            next_cycle();
            if (spawn_valid)
                fail_run($sformatf("error: %s saw a spawn that should not happen", test_name));
        end
    endtask

    // --------------------
    // directed tests
    task automatic test_after_reset();
        check_value("after_reset", 0, money);
        check_value("after_reset", 0, purse_level);
        check_value("after_reset", 0, able_to_upgrade);
        check_value("after_reset", 0, spawn_valid);
    endtask

    task automatic test_income_level0();
        game_init = 1'b1;
        next_cycle();
        game_init = 1'b0;
        exp_money = 0;
        exp_level = 0;
        repeat (60) tick_and_check("income_level0");
        check_value("income_level0", 60, money);
        check_value("income_level0", 1, able_to_upgrade);
    endtask

    task automatic test_purchases();
        click_buttons(8'b0000_0010, 1'b0);  // white_bear costs more than the purse
        expect_no_spawn("purchases");
        check_value("purchases", exp_money, money);
        click_buttons(8'b0000_0001, 1'b0);
        wait_for_spawn("purchases", killer_bird);
        check_value("purchases", 0, able_to_upgrade);
        expect_no_spawn("purchases");
    endtask

    task automatic test_upgrade();
        int n;
        while (exp_money < upgrade_price_at(exp_level))
            tick_and_check("upgrade");
        click_buttons('0, 1'b1);
        for (n = 0; n < SPAWN_WAIT && purse_level != exp_level + 1; n++)
            next_cycle();
        exp_money = exp_money - upgrade_price_at(exp_level);
        exp_level = exp_level + 1;
        check_value("upgrade", exp_level, purse_level);
        check_value("upgrade", exp_money, money);
        repeat (5) tick_and_check("upgrade");   // +2 each at level 1
    endtask

    task automatic test_cap();
        repeat (500) tick_and_check("cap");
        check_value("cap", money_cap_at(exp_level), money);
        repeat (5) tick_and_check("cap");
    endtask

    task automatic test_queued_buys();
        logic [`ECON_UNIT_TYPES-1:0] mask;
        int total;
        int start_money;
        do begin
            mask  = $random(seed);
            total = 0;
            for (int i = 0; i < `ECON_UNIT_TYPES; i++)
                if (mask[i])
                    total += cost_of_unit(i);
        end while (mask == '0 || total > exp_money);    // affordable masks only
        start_money = exp_money;
        click_buttons(mask, 1'b0);
        for (int i = 0; i < `ECON_UNIT_TYPES; i++)
            if (mask[i])
                wait_for_spawn("queued_buys", i);
        check_value("queued_buys", start_money - total, money);
        expect_no_spawn("queued_buys");
    endtask

    initial begin
        clk_25MHz     = 1'b0;
        rst           = 1'b1;
        game_init     = 1'b0;
        tick          = 1'b0;
        buy_click     = '0;
        upgrade_click = 1'b0;
        exp_money     = 0;
        exp_level     = 0;
        repeat (4) @(posedge clk_25MHz);
        #2;
        rst = 1'b0;

        test_after_reset();
        test_income_level0();
        test_purchases();
        test_upgrade();
        test_cap();
        test_queued_buys();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
